// ==== Makefile ====
# Verilator build and run for the serial command bridge.
# Any variable below can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_uart_cmd_bridge
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_TEXT := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_cmd_bridge.sv
verification/uart_remote_model.sv
verification/tb_uart_cmd_bridge.sv

// ==== verification/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  import uart_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int GAP_CYCLES   = 100;
  localparam int RESP_TIMEOUT = 400;
  localparam int ACK_LIMIT    = 2000;

  localparam int MODE_GOOD     = 0;
  localparam int MODE_BAD_PAR  = 1;
  localparam int MODE_BAD_STOP = 2;
  localparam int MODE_SILENT   = 3;

  typedef struct packed {
    logic [1:0]   num_bytes;
    logic [7:0]   byte_hi;
    logic [7:0]   byte_lo;
    logic [7:0]   rd_data;
    logic         check_rd;
    resp_status_e status;
  } expect_t;

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_req;
  logic [CMD_WIDTH-1:0] cmd_word;
  logic                 cmd_ack;
  logic [DATA_BITS-1:0] rd_data;
  resp_status_e         status;
  logic                 tx;
  logic                 rx;
  int                   reply_mode;
  logic [7:0]           reply_byte;
  logic [31:0]          rng_state;

  uart_cmd_bridge #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_word (cmd_word),
    .cmd_ack  (cmd_ack),
    .rd_data  (rd_data),
    .status   (status),
    .tx       (tx),
    .rx       (rx)
  );

  uart_remote_model #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_remote (
    .clk        (clk),
    .line_in    (tx),
    .line_out   (rx),
    .reply_mode (reply_mode),
    .reply_byte (reply_byte)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // a write sends both bytes and returns nothing, a read returns the reply byte.
  function automatic expect_t expected_result(input logic [15:0] cmd, input int mode,
                                              input logic [7:0] reply);
    expect_t e;
    e.byte_hi  = cmd[15:8];
    e.byte_lo  = cmd[7:0];
    e.check_rd = 1'b1;
    if (cmd_op_e'(cmd[15]) == OP_WRITE)
    begin
      e.num_bytes = 2'd2;
      e.rd_data   = 8'h00;
      e.status    = ST_OK;
    end
    else
    begin
      e.num_bytes = 2'd1;
      e.rd_data   = reply;
      case (mode)
        MODE_GOOD:     e.status = ST_OK;
        MODE_BAD_PAR:  e.status = ST_PARITY;
        MODE_BAD_STOP: e.status = ST_FRAMING;
        default:
        begin
          e.status   = ST_TIMEOUT;
          e.check_rd = 1'b0;
        end
      endcase
    end
    return e;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    while (cmd_ack !== level)
    begin
      if (cycles == ACK_LIMIT)
        stop_on_error($sformatf("cmd_ack did not go %s within %0d cycles",
                                level ? "high" : "low", ACK_LIMIT));
      @(negedge clk);
      cycles++;
    end
  endtask

  // one full handshake, entered and left on a falling edge.
  task automatic run_command(input logic [15:0] cmd, input int mode,
                             input logic [7:0] reply, input int hold);
    expect_t exp;
    int      first;
    exp        = expected_result(cmd, mode, reply);
    first      = u_remote.rec_count;
    reply_mode = mode;
    reply_byte = reply;
    cmd_word   = cmd;
    cmd_req    = 1'b1;
    wait_ack(1'b1);
    check_value("status", status, exp.status);
    if (exp.check_rd)
      check_value("rd_data", rd_data, exp.rd_data);
    check_value("frames seen by remote", u_remote.rec_count - first, exp.num_bytes);
    check_value("remote byte 0", u_remote.rec_data[first % 256], exp.byte_hi);
    check_value("remote byte 0 good", u_remote.rec_good[first % 256], 1);
    if (exp.num_bytes == 2'd2)
    begin
      check_value("remote byte 1", u_remote.rec_data[(first + 1) % 256], exp.byte_lo);
      check_value("remote byte 1 good", u_remote.rec_good[(first + 1) % 256], 1);
    end
    repeat (hold)
    begin
      @(negedge clk);
      check_value("cmd_ack while cmd_req held", cmd_ack, 1);
    end
    cmd_req = 1'b0;
    wait_ack(1'b0);
  endtask

  initial
  begin
    logic [31:0] r;
    int          mode;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_req    = 1'b0;
    cmd_word   = '0;
    reply_mode = MODE_SILENT;
    reply_byte = 8'h00;
    rng_state  = 32'd48961;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // nothing may happen on the line before the first request.
    repeat (40)
    begin
      @(negedge clk);
      check_value("tx", tx, 1);
      check_value("cmd_ack", cmd_ack, 0);
      check_value("status", status, ST_OK);
      check_value("rd_data", rd_data, 0);
    end
    check_value("frames seen by remote", u_remote.rec_count, 0);

    repeat (4)
    begin
      r = next_rand();
      run_command({1'b1, r[14:0]}, MODE_SILENT, 8'h00, 0);
    end

    repeat (4)
    begin
      r = next_rand();
      run_command({1'b0, r[14:0]}, MODE_GOOD, r[23:16], 0);
    end

    r = next_rand();
    run_command({1'b0, r[14:0]}, MODE_BAD_PAR, r[23:16], 0);
    run_command({1'b0, r[30:16]}, MODE_BAD_STOP, r[7:0], 0);
    run_command({1'b0, r[14:0]}, MODE_SILENT, r[23:16], 0);

    r = next_rand();
    run_command({1'b0, r[14:0]}, MODE_GOOD, r[23:16], 12);
    run_command({1'b1, r[14:0]}, MODE_SILENT, 8'h00, 7);

    repeat (20)
    begin
      r    = next_rand();
      mode = r[15] ? MODE_SILENT : int'(r[17:16]);
      run_command(r[15:0], mode, r[31:24], 0);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== verification/uart_remote_model.sv ====
`timescale 1ns/1ps

module uart_remote_model #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       line_in,
  output logic       line_out,
  input  int         reply_mode,
  input  logic [7:0] reply_byte
);

  localparam int MODE_BAD_PAR  = 1;
  localparam int MODE_BAD_STOP = 2;
  localparam int MODE_SILENT   = 3;

  // every decoded byte, with a flag for good start, parity and stop bits.
  logic [7:0] rec_data [0:255];
  logic       rec_good [0:255];
  int         rec_count;
  logic       prev_line;

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // called one half clock after the start bit began on the line.
  task automatic receive_frame();
    logic [7:0] data;
    logic       start_bit;
    logic       par_bit;
    logic       stop_bit;
    int         i;
    wait_clocks(CLKS_PER_BIT / 2);
    start_bit = line_in;
    for (i = 0; i < 8; i++)
    begin
      wait_clocks(CLKS_PER_BIT);
      data[i] = line_in;
    end
    wait_clocks(CLKS_PER_BIT);
    par_bit = line_in;
    wait_clocks(CLKS_PER_BIT);
    stop_bit = line_in;
    rec_data[rec_count % 256] = data;
    rec_good[rec_count % 256] = !start_bit && (^{data, par_bit} == 1'b1) && stop_bit;
    rec_count++;
  endtask

  task automatic send_frame(input logic [7:0] data, input int mode);
    logic [10:0] frame;
    logic        par_bit;
    int          i;
    par_bit = (mode == MODE_BAD_PAR) ? ^data : ~^data;
    frame   = {(mode != MODE_BAD_STOP), par_bit, data, 1'b0};
    for (i = 0; i < 11; i++)
    begin
      line_out = frame[i];
      wait_clocks(CLKS_PER_BIT);
    end
    line_out = 1'b1;
  endtask

  // the line is looked at on the falling clock edge, away from the DUT's updates.
  initial
  begin
    line_out  = 1'b1;
    rec_count = 0;
    prev_line = 1'b1;
    forever
    begin
      @(negedge clk);
      if (prev_line === 1'b1 && line_in === 1'b0)
      begin
        receive_frame();
        if (reply_mode != MODE_SILENT)
        begin
          wait_clocks(CLKS_PER_BIT / 2 + 2 * CLKS_PER_BIT);
          send_frame(reply_byte, reply_mode);
        end
      end
      prev_line = line_in;
    end
  end

endmodule

// ==== verilog/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 20000
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_req,
  input  logic [uart_pkg::CMD_WIDTH-1:0] cmd_word,
  output logic                           cmd_ack,
  output logic [uart_pkg::DATA_BITS-1:0] rd_data,
  output uart_pkg::resp_status_e         status,
  output logic                           tx,
  input  logic                           rx
);

  import uart_pkg::*;

  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_data;
  logic                 tx_busy;
  logic                 rx_arm;
  logic                 rx_started;
  logic                 rx_done;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_parity_err;
  logic                 rx_frame_err;

  uart_cmd_ctrl #(
    .GAP_CYCLES   (GAP_CYCLES),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_req       (cmd_req),
    .cmd_word      (cmd_word),
    .cmd_ack       (cmd_ack),
    .rd_data       (rd_data),
    .status        (status),
    .tx_start      (tx_start),
    .tx_data       (tx_data),
    .tx_busy       (tx_busy),
    .rx_arm        (rx_arm),
    .rx_started    (rx_started),
    .rx_done       (rx_done),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_arm        (rx_arm),
    .rx            (rx),
    .rx_started    (rx_started),
    .rx_done       (rx_done),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

// ==== verilog/uart_cmd_ctrl.sv ====
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int GAP_CYCLES   = 100,
  parameter int RESP_TIMEOUT = 20000
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_req,
  input  logic [uart_pkg::CMD_WIDTH-1:0] cmd_word,
  output logic                           cmd_ack,
  output logic [uart_pkg::DATA_BITS-1:0] rd_data,
  output uart_pkg::resp_status_e         status,
  output logic                           tx_start,
  output logic [uart_pkg::DATA_BITS-1:0] tx_data,
  input  logic                           tx_busy,
  output logic                           rx_arm,
  input  logic                           rx_started,
  input  logic                           rx_done,
  input  logic [uart_pkg::DATA_BITS-1:0] rx_data,
  input  logic                           rx_parity_err,
  input  logic                           rx_frame_err
);

  import uart_pkg::*;

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);
  localparam int TMO_W = $clog2(RESP_TIMEOUT + 1);

  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 1);
  // counting starts one cycle after the address frame ends.
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(RESP_TIMEOUT - 2);

  ctrl_state_e          state_q;
  ctrl_state_e          state_d;
  cmd_op_e              op;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic [GAP_W-1:0]     gap_cnt;
  logic [TMO_W-1:0]     tmo_cnt;
  logic                 resp_seen;
  logic                 start_cmd;
  logic                 frame_sent;
  logic                 gap_done;
  logic                 timed_out;

  assign op         = cmd_op_e'(cmd_q[CMD_WIDTH-1]);
  assign start_cmd  = (state_q == S_IDLE) && cmd_req;
  // tx_busy only rises the cycle after tx_start, so both must be low.
  assign frame_sent = !tx_busy && !tx_start;
  assign gap_done   = (gap_cnt == GAP_LAST);
  assign timed_out  = !resp_seen && !rx_started && (tmo_cnt == TMO_LAST);
  assign rx_arm     = (state_q == S_WAIT_RESP);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (cmd_req)
          state_d = S_SEND_HI;
      S_SEND_HI:
        if (frame_sent)
          state_d = (op == OP_WRITE) ? S_GAP : S_WAIT_RESP;
      S_GAP:
        if (gap_done)
          state_d = S_SEND_LO;
      S_SEND_LO:
        if (frame_sent)
          state_d = S_ACK;
      S_WAIT_RESP:
        if (rx_done || timed_out)
          state_d = S_ACK;
      S_ACK:
        if (!cmd_req)
          state_d = S_IDLE;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= S_IDLE;
      cmd_ack   <= 1'b0;
      rd_data   <= '0;
      status    <= ST_OK;
      tx_start  <= 1'b0;
      gap_cnt   <= '0;
      tmo_cnt   <= '0;
      resp_seen <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cmd_ack  <= (state_d == S_ACK);
      tx_start <= start_cmd || ((state_q == S_GAP) && gap_done);
      gap_cnt  <= (state_q == S_GAP) ? gap_cnt + 1'b1 : '0;

      if (state_q == S_WAIT_RESP)
      begin
        if (rx_started)
          resp_seen <= 1'b1;
        if (!resp_seen)
          tmo_cnt <= tmo_cnt + 1'b1;
      end
      else
      begin
        resp_seen <= 1'b0;
        tmo_cnt   <= '0;
      end

      if (start_cmd)
      begin
        rd_data <= '0;
        status  <= ST_OK;
      end
      else if (state_q == S_WAIT_RESP)
      begin
        if (rx_done)
        begin
          rd_data <= rx_data;
          status  <= rx_frame_err ? ST_FRAMING : (rx_parity_err ? ST_PARITY : ST_OK);
        end
        else if (timed_out)
        begin
          status <= ST_TIMEOUT;
        end
      end
    end
  end

  // the high byte goes first, the low byte follows only for a write.
  always_ff @(posedge clk)
  begin
    if (start_cmd)
    begin
      cmd_q   <= cmd_word;
      tx_data <= cmd_word[CMD_WIDTH-1 -: DATA_BITS];
    end
    else if ((state_q == S_GAP) && gap_done)
    begin
      tx_data <= cmd_q[DATA_BITS-1:0];
    end
  end

  a_ack_held_with_req: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_ack && cmd_req |=> cmd_ack
  );

  a_word_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(cmd_req && !cmd_ack) && cmd_req && !cmd_ack |-> $stable(cmd_word)
  );

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

  // command word as presented by the host.
  localparam int CMD_WIDTH = 16;

  // one frame is a start bit, the data bits, an odd parity bit and a stop bit.
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;

  // bit 15 of the command word.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // result reported to the host together with cmd_ack.
  typedef enum logic [1:0] {
    ST_OK      = 2'd0,
    ST_PARITY  = 2'd1,
    ST_FRAMING = 2'd2,
    ST_TIMEOUT = 2'd3
  } resp_status_e;

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_SEND_HI   = 3'd1,
    S_GAP       = 3'd2,
    S_SEND_LO   = 3'd3,
    S_WAIT_RESP = 3'd4,
    S_ACK       = 3'd5
  } ctrl_state_e;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           rx_arm,
  input  logic                           rx,
  output logic                           rx_started,
  output logic                           rx_done,
  output logic [uart_pkg::DATA_BITS-1:0] rx_data,
  output logic                           rx_parity_err,
  output logic                           rx_frame_err
);

  import uart_pkg::*;

  localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W  = $clog2(FRAME_BITS + 1);

  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] HALF_LAST = BAUD_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0]  PAR_IDX   = IDX_W'(FRAME_BITS - 2);
  localparam logic [IDX_W-1:0]  STOP_IDX  = IDX_W'(FRAME_BITS - 1);
  // one extra half bit after the stop sample marks the end of the frame.
  localparam logic [IDX_W-1:0]  END_IDX   = IDX_W'(FRAME_BITS);

  logic [2:0]           rx_sync;
  logic                 line;
  logic                 fall_edge;
  logic                 active;
  logic [IDX_W-1:0]     bit_idx;
  logic [BAUD_W-1:0]    baud_cnt;
  logic                 half_phase;
  logic                 sample_tick;
  logic                 sample_en;
  logic [DATA_BITS-1:0] shift_q;
  logic                 par_q;
  logic                 stop_q;

  assign line      = rx_sync[1];
  assign fall_edge = rx_sync[2] && !rx_sync[1];

  // start and end phases are half a bit long, the rest a full bit from mid to mid.
  assign half_phase  = (bit_idx == '0) || (bit_idx == END_IDX);
  assign sample_tick = half_phase ? (baud_cnt == HALF_LAST) : (baud_cnt == BAUD_LAST);
  assign sample_en   = rx_arm && active && sample_tick;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync    <= '1;
      active     <= 1'b0;
      bit_idx    <= '0;
      baud_cnt   <= '0;
      rx_started <= 1'b0;
      rx_done    <= 1'b0;
    end
    else
    begin
      rx_sync    <= {rx_sync[1:0], rx};
      rx_started <= 1'b0;
      rx_done    <= 1'b0;
      if (!rx_arm)
      begin
        active <= 1'b0;
      end
      else if (!active)
      begin
        if (fall_edge)
        begin
          active   <= 1'b1;
          bit_idx  <= '0;
          baud_cnt <= '0;
        end
      end
      else if (sample_tick)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0)
        begin
          if (line)
            active <= 1'b0;  // glitch, not a start bit
          else
            rx_started <= 1'b1;
        end
        else if (bit_idx == END_IDX)
        begin
          active  <= 1'b0;
          rx_done <= 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_en)
    begin
      if (bit_idx != '0 && bit_idx < PAR_IDX)
        shift_q <= {line, shift_q[DATA_BITS-1:1]};
      if (bit_idx == PAR_IDX)
        par_q <= line;
      if (bit_idx == STOP_IDX)
        stop_q <= line;
      if (bit_idx == END_IDX)
      begin
        rx_data       <= shift_q;
        rx_parity_err <= ~^{shift_q, par_q};
        rx_frame_err  <= ~stop_q;
      end
    end
  end

  a_started_done_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(rx_started && rx_done)
  );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           tx_start,
  input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
  output logic                           tx_busy,
  output logic                           tx
);

  import uart_pkg::*;

  localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
  localparam int CNT_W  = $clog2(FRAME_BITS);

  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0]  LAST_BIT  = CNT_W'(FRAME_BITS - 1);

  // everything after the start bit: data lsb first, parity, stop.
  logic [FRAME_BITS-2:0] shift_q;
  logic [CNT_W-1:0]      bit_cnt;
  logic [BAUD_W-1:0]     baud_cnt;
  logic                  load;
  logic                  baud_tick;

  assign load      = tx_start && !tx_busy;
  assign baud_tick = (baud_cnt == BAUD_LAST);

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      // odd parity makes the count of ones over data and parity odd.
      shift_q <= {1'b1, ~^tx_data, tx_data};
    end
    else if (tx_busy && baud_tick)
    begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end
    else if (load)
    begin
      // the start bit goes out on the cycle after tx_start.
      tx_busy  <= 1'b1;
      tx       <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end
    else if (tx_busy)
    begin
      if (baud_tick)
      begin
        baud_cnt <= '0;
        if (bit_cnt == LAST_BIT)
        begin
          tx_busy <= 1'b0;
          tx      <= 1'b1;
        end
        else
        begin
          tx      <= shift_q[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // the controller must wait for the current frame before starting another.
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) !(tx_start && tx_busy)
  );

endmodule
